// ==== verilog/scr1_dmem_pkg.sv ====
`default_nettype none
//----------------------------------------------------------
// Shared types and constants of the data memory subsystem.
// Address map, response codes and timer register offsets,
// imported by every module of the design and the testbench.
//----------------------------------------------------------

package scr1_dmem_pkg;

//----------------------------------------------------------
// Data path widths
//----------------------------------------------------------
typedef logic [31:0] scr1_addr_t;
typedef logic [31:0] scr1_data_t;
typedef logic [63:0] scr1_timer_val_t;
typedef logic [4:0]  scr1_timer_ofs_t;      // Byte offset inside the timer window

// Memory request encodings, same as the core's LSU
typedef enum logic [1:0] {
    BYTE  = 2'b00,
    HWORD = 2'b01,
    WORD  = 2'b10
} scr1_mem_width_e;

typedef enum logic {
    RD = 1'b0,
    WR = 1'b1
} scr1_mem_cmd_e;

typedef enum logic [1:0] {
    IDLE   = 2'b00,
    RDY_OK = 2'b01,
    RDY_ER = 2'b10
} scr1_mem_resp_e;

//----------------------------------------------------------
// Address map
//----------------------------------------------------------
localparam scr1_addr_t SCR1_TCM_ADDR_MASK      = 32'hFFFF_F000;   // 4 KiB
localparam scr1_addr_t SCR1_TCM_ADDR_PATTERN   = 32'h0048_0000;
localparam scr1_addr_t SCR1_TIMER_ADDR_MASK    = 32'hFFFF_FFE0;   // 32 bytes
localparam scr1_addr_t SCR1_TIMER_ADDR_PATTERN = 32'h0049_0000;

localparam int unsigned SCR1_TCM_WORDS = 1024;
localparam int unsigned SCR1_TCM_IDX_W = $clog2(SCR1_TCM_WORDS);
typedef logic [SCR1_TCM_IDX_W-1:0] scr1_tcm_idx_t;

// Timer registers, word access only
localparam scr1_timer_ofs_t SCR1_TIMER_CTRL      = 5'h00;
localparam scr1_timer_ofs_t SCR1_TIMER_DIV       = 5'h04;
localparam scr1_timer_ofs_t SCR1_TIMER_MTIMELO   = 5'h08;
localparam scr1_timer_ofs_t SCR1_TIMER_MTIMEHI   = 5'h0C;
localparam scr1_timer_ofs_t SCR1_TIMER_MTIMECMPLO = 5'h10;
localparam scr1_timer_ofs_t SCR1_TIMER_MTIMECMPHI = 5'h14;

endpackage : scr1_dmem_pkg

`default_nettype wire

// ==== verilog/scr1_dmem_if.sv ====
`default_nettype none
//----------------------------------------------------------
// One data memory port with the req/req_ack/resp protocol.
// The router drives the master side, a target the slave side.
//----------------------------------------------------------

interface scr1_dmem_if
    import scr1_dmem_pkg::*;
();

    logic            req;
    scr1_mem_cmd_e   cmd;
    scr1_mem_width_e width;
    scr1_addr_t      addr;
    scr1_data_t      wdata;
    logic            req_ack;       // Request taken this cycle
    scr1_data_t      rdata;         // Valid with resp, reads only
    scr1_mem_resp_e  resp;

    modport master (
        output req, cmd, width, addr, wdata,
        input  req_ack, rdata, resp
    );

    modport slave (
        input  req, cmd, width, addr, wdata,
        output req_ack, rdata, resp
    );

endinterface : scr1_dmem_if

`default_nettype wire

// ==== verilog/scr1_dmem_router.sv ====
`default_nettype none
//----------------------------------------------------------
// Data memory address decoder. Steers core requests to the
// TCM or the timer and returns their responses. Unmapped
// addresses are answered here with an error.
//----------------------------------------------------------

module scr1_dmem_router
    import scr1_dmem_pkg::*;
(
    input  logic            clk,
    input  logic            core_rst_n_local,

    // Core side
    input  logic            dmem_req_i,
    input  scr1_mem_cmd_e   dmem_cmd_i,
    input  scr1_mem_width_e dmem_width_i,
    input  scr1_addr_t      dmem_addr_i,
    input  scr1_data_t      dmem_wdata_i,
    output logic            dmem_req_ack_o,
    output scr1_data_t      dmem_rdata_o,
    output scr1_mem_resp_e  dmem_resp_o,

    // Targets
    scr1_dmem_if.master     tcm_m,
    scr1_dmem_if.master     timer_m
);

// Target of the response due in the current cycle
typedef enum logic [1:0] {
    SEL_IDLE,
    SEL_TCM,
    SEL_TIMER,
    SEL_ERR
} sel_state_e;

sel_state_e sel_q;
sel_state_e sel_d;
logic       tcm_hit;
logic       timer_hit;

assign tcm_hit   = (dmem_addr_i & SCR1_TCM_ADDR_MASK) == SCR1_TCM_ADDR_PATTERN;
assign timer_hit = (dmem_addr_i & SCR1_TIMER_ADDR_MASK) == SCR1_TIMER_ADDR_PATTERN;

//----------------------------------------------------------
// Request path
//----------------------------------------------------------
assign tcm_m.req     = dmem_req_i & tcm_hit;
assign tcm_m.cmd     = dmem_cmd_i;
assign tcm_m.width   = dmem_width_i;
assign tcm_m.addr    = dmem_addr_i;
assign tcm_m.wdata   = dmem_wdata_i;

assign timer_m.req   = dmem_req_i & timer_hit;
assign timer_m.cmd   = dmem_cmd_i;
assign timer_m.width = dmem_width_i;
assign timer_m.addr  = dmem_addr_i;
assign timer_m.wdata = dmem_wdata_i;

always_comb begin
    if (tcm_hit) begin
        dmem_req_ack_o = tcm_m.req_ack;
    end else if (timer_hit) begin
        dmem_req_ack_o = timer_m.req_ack;
    end else begin
        dmem_req_ack_o = 1'b1;      // Error answered locally
    end
end

always_comb begin
    if (~(dmem_req_i & dmem_req_ack_o)) begin
        sel_d = SEL_IDLE;
    end else if (tcm_hit) begin
        sel_d = SEL_TCM;
    end else if (timer_hit) begin
        sel_d = SEL_TIMER;
    end else begin
        sel_d = SEL_ERR;
    end
end

always_ff @(posedge clk) begin
    if (~core_rst_n_local) begin
        sel_q <= SEL_IDLE;
    end else begin
        sel_q <= sel_d;
    end
end

//----------------------------------------------------------
// Response path
//----------------------------------------------------------
always_comb begin
    case (sel_q)
        SEL_TCM: begin
            dmem_rdata_o = tcm_m.rdata;
            dmem_resp_o  = tcm_m.resp;
        end
        SEL_TIMER: begin
            dmem_rdata_o = timer_m.rdata;
            dmem_resp_o  = timer_m.resp;
        end
        SEL_ERR: begin
            dmem_rdata_o = '0;
            dmem_resp_o  = RDY_ER;
        end
        default: begin
            dmem_rdata_o = '0;
            dmem_resp_o  = IDLE;
        end
    endcase
end

// Address windows must not overlap
a_no_double_hit : assert property (@(posedge clk) disable iff (~core_rst_n_local)
    !(tcm_hit && timer_hit));

// A forwarded TCM request is answered by the TCM in the next cycle
a_tcm_resp_due : assert property (@(posedge clk) disable iff (~core_rst_n_local)
    (sel_q == SEL_TCM) |-> (tcm_m.resp != IDLE));

endmodule : scr1_dmem_router

`default_nettype wire

// ==== verilog/scr1_tcm.sv ====
`default_nettype none
//----------------------------------------------------------
// Single-port data RAM behind the router. Byte, halfword
// and word writes; reads return the aligned word.
//----------------------------------------------------------

module scr1_tcm
    import scr1_dmem_pkg::*;
(
    input  logic        clk,
    input  logic        core_rst_n_local,
    scr1_dmem_if.slave  mem_s
);

scr1_data_t     mem [SCR1_TCM_WORDS];
scr1_tcm_idx_t  word_idx;
logic [3:0]     byte_en;
scr1_data_t     wr_data;
logic           addr_err;
logic           req_acc;
logic           mem_wr;
logic           mem_rd;
scr1_mem_resp_e resp_q;
scr1_data_t     rdata_q;

assign mem_s.req_ack = 1'b1;        // Never stalls
assign req_acc       = mem_s.req & mem_s.req_ack;
assign word_idx      = mem_s.addr[SCR1_TCM_IDX_W+1:2];

// Write data arrives in the low lanes, moved to its byte position here
assign wr_data = mem_s.wdata << {mem_s.addr[1:0], 3'b000};

//----------------------------------------------------------
// Byte enables and alignment check
//----------------------------------------------------------
always_comb begin
    byte_en  = '0;
    addr_err = 1'b0;
    case (mem_s.width)
        BYTE: byte_en = 4'b0001 << mem_s.addr[1:0];
        HWORD: begin
            if (mem_s.addr[1:0] == 2'b11) begin
                addr_err = 1'b1;    // Would cross the word
            end else begin
                byte_en = 4'b0011 << mem_s.addr[1:0];
            end
        end
        WORD: begin
            if (mem_s.addr[1:0] != 2'b00) begin
                addr_err = 1'b1;
            end else begin
                byte_en = 4'b1111;
            end
        end
        default: addr_err = 1'b1;
    endcase
end

assign mem_wr = req_acc & (mem_s.cmd == WR) & ~addr_err;
assign mem_rd = req_acc & (mem_s.cmd == RD);

always_ff @(posedge clk) begin
    if (mem_wr) begin
        for (int i = 0; i < 4; i++) begin
            if (byte_en[i]) begin
                mem[word_idx][8*i +: 8] <= wr_data[8*i +: 8];
            end
        end
    end
    if (mem_rd) begin
        rdata_q <= mem[word_idx];
    end
end

always_ff @(posedge clk) begin
    if (~core_rst_n_local) begin
        resp_q <= IDLE;
    end else if (req_acc) begin
        resp_q <= addr_err ? RDY_ER : RDY_OK;
    end else begin
        resp_q <= IDLE;
    end
end

assign mem_s.rdata = rdata_q;
assign mem_s.resp  = resp_q;

// No response without a request accepted one cycle before
a_no_spurious_ok : assert property (@(posedge clk) disable iff (~core_rst_n_local)
    !(mem_s.req && mem_s.req_ack) |=> (mem_s.resp != RDY_OK));

endmodule : scr1_tcm

`default_nettype wire

// ==== verilog/scr1_timer.sv ====
`default_nettype none
//----------------------------------------------------------
// Memory-mapped machine timer. 64-bit mtime counts on a
// prescaled clk and raises timer_irq_o at mtimecmp.
//----------------------------------------------------------

module scr1_timer
    import scr1_dmem_pkg::*;
(
    input  logic            clk,
    input  logic            core_rst_n_local,
    scr1_dmem_if.slave      mem_s,
    output scr1_timer_val_t timer_val_o,
    output logic            timer_irq_o
);

logic            timer_en_q, timer_en_d;
scr1_data_t      div_q, div_d;
scr1_data_t      presc_q, presc_d;
scr1_timer_val_t mtime_q, mtime_d;
scr1_timer_val_t mtimecmp_q, mtimecmp_d;
logic            irq_q;
scr1_mem_resp_e  resp_q;
scr1_data_t      rdata_q, rdata_d;
scr1_timer_ofs_t reg_ofs;
logic            req_acc;
logic            reg_err;
logic            reg_wr;
logic            tick;

assign mem_s.req_ack = 1'b1;
assign req_acc       = mem_s.req & mem_s.req_ack;
assign reg_ofs       = mem_s.addr[4:0];
assign tick          = timer_en_q & (presc_q == div_q);    // Every DIV+1 cycles

//----------------------------------------------------------
// Register decode and read mux
//----------------------------------------------------------
always_comb begin
    reg_err = (mem_s.width != WORD);
    rdata_d = '0;
    case (reg_ofs)
        SCR1_TIMER_CTRL:       rdata_d = scr1_data_t'(timer_en_q);
        SCR1_TIMER_DIV:        rdata_d = div_q;
        SCR1_TIMER_MTIMELO:    rdata_d = mtime_q[31:0];
        SCR1_TIMER_MTIMEHI:    rdata_d = mtime_q[63:32];
        SCR1_TIMER_MTIMECMPLO: rdata_d = mtimecmp_q[31:0];
        SCR1_TIMER_MTIMECMPHI: rdata_d = mtimecmp_q[63:32];
        default:               reg_err = 1'b1;
    endcase
end

assign reg_wr = req_acc & (mem_s.cmd == WR) & ~reg_err;

//----------------------------------------------------------
// Next state, bus writes take priority over counting
//----------------------------------------------------------
always_comb begin
    timer_en_d = timer_en_q;
    div_d      = div_q;
    mtimecmp_d = mtimecmp_q;
    mtime_d    = tick ? mtime_q + 1'b1 : mtime_q;
    presc_d    = (~timer_en_q | tick) ? '0 : presc_q + 1'b1;
    if (reg_wr) begin
        case (reg_ofs)
            SCR1_TIMER_CTRL: timer_en_d = mem_s.wdata[0];
            SCR1_TIMER_DIV: begin
                div_d   = mem_s.wdata;
                presc_d = '0;       // Restart the period
            end
            SCR1_TIMER_MTIMELO:    mtime_d    = {mtime_q[63:32], mem_s.wdata};
            SCR1_TIMER_MTIMEHI:    mtime_d    = {mem_s.wdata, mtime_q[31:0]};
            SCR1_TIMER_MTIMECMPLO: mtimecmp_d = {mtimecmp_q[63:32], mem_s.wdata};
            SCR1_TIMER_MTIMECMPHI: mtimecmp_d = {mem_s.wdata, mtimecmp_q[31:0]};
            default: ;
        endcase
    end
end

always_ff @(posedge clk) begin
    if (~core_rst_n_local) begin
        timer_en_q <= 1'b0;
        div_q      <= '0;
        presc_q    <= '0;
        mtime_q    <= '0;
        mtimecmp_q <= '1;
        irq_q      <= 1'b0;
        resp_q     <= IDLE;
    end else begin
        timer_en_q <= timer_en_d;
        div_q      <= div_d;
        presc_q    <= presc_d;
        mtime_q    <= mtime_d;
        mtimecmp_q <= mtimecmp_d;
        irq_q      <= timer_en_d & (mtime_d >= mtimecmp_d);
        resp_q     <= req_acc ? (reg_err ? RDY_ER : RDY_OK) : IDLE;
    end
end

always_ff @(posedge clk) begin
    if (req_acc) begin
        rdata_q <= rdata_d;
    end
end

assign mem_s.rdata = rdata_q;
assign mem_s.resp  = resp_q;
assign timer_val_o = mtime_q;
assign timer_irq_o = irq_q;

// Interrupt only while the timer runs
a_irq_needs_en : assert property (@(posedge clk) disable iff (~core_rst_n_local)
    !timer_en_q |-> !timer_irq_o);

endmodule : scr1_timer

`default_nettype wire

// ==== verilog/scr1_dmem_top.sv ====
`default_nettype none
//----------------------------------------------------------
// Data memory subsystem top. Core data port in, router in
// front of the TCM and the machine timer.
//----------------------------------------------------------

module scr1_dmem_top
    import scr1_dmem_pkg::*;
(
    input  logic            clk,                // System clock
    input  logic            core_rst_n_local,   // Core reset, active low

    // Core data memory port
    input  logic            dmem_req_i,
    input  scr1_mem_cmd_e   dmem_cmd_i,
    input  scr1_mem_width_e dmem_width_i,
    input  scr1_addr_t      dmem_addr_i,
    input  scr1_data_t      dmem_wdata_i,
    output logic            dmem_req_ack_o,
    output scr1_data_t      dmem_rdata_o,
    output scr1_mem_resp_e  dmem_resp_o,

    // Timer to the core
    output logic            timer_irq_o,
    output scr1_timer_val_t timer_val_o
);

//----------------------------------------------------------
// Router to target ports
//----------------------------------------------------------
scr1_dmem_if tcm_if ();
scr1_dmem_if timer_if ();

//----------------------------------------------------------
// Data memory router
//----------------------------------------------------------
scr1_dmem_router u_dmem_router (
    .clk                (clk             ),
    .core_rst_n_local   (core_rst_n_local),
    .dmem_req_i         (dmem_req_i      ),
    .dmem_cmd_i         (dmem_cmd_i      ),
    .dmem_width_i       (dmem_width_i    ),
    .dmem_addr_i        (dmem_addr_i     ),
    .dmem_wdata_i       (dmem_wdata_i    ),
    .dmem_req_ack_o     (dmem_req_ack_o  ),
    .dmem_rdata_o       (dmem_rdata_o    ),
    .dmem_resp_o        (dmem_resp_o     ),
    .tcm_m              (tcm_if.master   ),
    .timer_m            (timer_if.master )
);

//----------------------------------------------------------
// TCM
//----------------------------------------------------------
scr1_tcm u_tcm (
    .clk                (clk             ),
    .core_rst_n_local   (core_rst_n_local),
    .mem_s              (tcm_if.slave    )
);

//----------------------------------------------------------
// Machine timer
//----------------------------------------------------------
scr1_timer u_timer (
    .clk                (clk             ),
    .core_rst_n_local   (core_rst_n_local),
    .mem_s              (timer_if.slave  ),
    .timer_val_o        (timer_val_o     ),
    .timer_irq_o        (timer_irq_o     )
);

endmodule : scr1_dmem_top

`default_nettype wire

// ==== dv/tb_scr1_dmem.sv ====
`default_nettype none
//----------------------------------------------------------
// Self-checking testbench of the data memory subsystem.
// Drives the core data port with seeded random traffic and
// checks TCM, unmapped and timer responses against a model.
//----------------------------------------------------------

module tb_scr1_dmem
    import scr1_dmem_pkg::*;
();

logic            clk;
logic            core_rst_n_local;
logic            dmem_req;
scr1_mem_cmd_e   dmem_cmd;
scr1_mem_width_e dmem_width;
scr1_addr_t      dmem_addr;
scr1_data_t      dmem_wdata;
logic            dmem_req_ack;
scr1_data_t      dmem_rdata;
scr1_mem_resp_e  dmem_resp;
logic            timer_irq;
scr1_timer_val_t timer_val;

integer          seed;
int              test_cnt;
int              check_cnt;
int              err_cnt;
int              test_err_base;
logic            timeout_hit;
logic [7:0]      tcm_model [4096];      // TCM contents, one entry per byte

scr1_dmem_top u_dut (
    .clk              (clk             ),
    .core_rst_n_local (core_rst_n_local),
    .dmem_req_i       (dmem_req        ),
    .dmem_cmd_i       (dmem_cmd        ),
    .dmem_width_i     (dmem_width      ),
    .dmem_addr_i      (dmem_addr       ),
    .dmem_wdata_i     (dmem_wdata      ),
    .dmem_req_ack_o   (dmem_req_ack    ),
    .dmem_rdata_o     (dmem_rdata      ),
    .dmem_resp_o      (dmem_resp       ),
    .timer_irq_o      (timer_irq       ),
    .timer_val_o      (timer_val       )
);

always #10 clk = ~clk;

// Ends the run once a wait loop has given up
always @(posedge clk) begin
    if (timeout_hit) begin
        $display("SIMULATION FAILED");
        $finish;
    end
end

//----------------------------------------------------------
// Check and bookkeeping helpers
//----------------------------------------------------------
task automatic compare_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    check_cnt++;
    assert (act === exp) else begin
        $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
        err_cnt++;
    end
endtask

task automatic end_test(input string name);
    test_cnt++;
    if (err_cnt == test_err_base) begin
        $display("test %-20s ok", name);
    end else begin
        $display("test %-20s failed with %0d errors", name, err_cnt - test_err_base);
    end
    test_err_base = err_cnt;
endtask

function automatic bit in_tcm_window(input scr1_addr_t addr);
    return (addr & SCR1_TCM_ADDR_MASK) == SCR1_TCM_ADDR_PATTERN;
endfunction

function automatic bit in_timer_window(input scr1_addr_t addr);
    return (addr & SCR1_TIMER_ADDR_MASK) == SCR1_TIMER_ADDR_PATTERN;
endfunction

function automatic scr1_addr_t timer_addr(input scr1_timer_ofs_t ofs);
    return SCR1_TIMER_ADDR_PATTERN | scr1_addr_t'(ofs);
endfunction

function automatic scr1_mem_width_e rand_width();
    int unsigned r;
    r = $unsigned($random(seed)) % 3;
    case (r)
        0:       return BYTE;
        1:       return HWORD;
        default: return WORD;
    endcase
endfunction

function automatic scr1_mem_cmd_e rand_cmd();
    return (($random(seed) & 1) != 0) ? WR : RD;
endfunction

// Fill value mixes every address bit
function automatic scr1_data_t fill_word(input scr1_addr_t addr);
    return (addr * 32'h9E37_79B9) ^ {addr[15:0], addr[31:16]};
endfunction

//----------------------------------------------------------
// Bus driver, one request per call
//----------------------------------------------------------
// Called on a falling edge; returns on the falling edge where the response is checked
task automatic xfer(input string name, input scr1_mem_cmd_e cmd, input scr1_mem_width_e width,
                    input scr1_addr_t addr, input scr1_data_t wdata,
                    input scr1_mem_resp_e exp_resp, input scr1_data_t exp_rdata,
                    input bit chk_data);
    int wait_cnt;
    wait_cnt   = 0;
    dmem_req   = 1'b1;
    dmem_cmd   = cmd;
    dmem_width = width;
    dmem_addr  = addr;
    dmem_wdata = wdata;
    @(posedge clk);
    while (!dmem_req_ack) begin
        wait_cnt++;
        if (wait_cnt > 16) begin
            $display("timeout: request to address %h was never acknowledged", addr);
            timeout_hit = 1'b1;
        end
        @(posedge clk);
    end
    @(negedge clk);                 // Response is due in this cycle
    compare_val({name, " resp"}, exp_resp, dmem_resp);
    if (chk_data) begin
        compare_val({name, " rdata"}, exp_rdata, dmem_rdata);
    end
endtask

task automatic idle_cycle();
    dmem_req = 1'b0;
    @(posedge clk);
    @(negedge clk);
    compare_val("idle resp", IDLE, dmem_resp);
endtask

//----------------------------------------------------------
// TCM model
//----------------------------------------------------------
// An access may not cross its word; reads return the aligned word
task automatic tcm_op(input string name, input scr1_mem_cmd_e cmd, input scr1_mem_width_e width,
                      input scr1_addr_t addr, input scr1_data_t wdata);
    logic [11:0]    ofs;
    logic [11:0]    base;
    int             nbytes;
    int             i;
    scr1_mem_resp_e resp;
    scr1_data_t     rdata;
    ofs    = addr[11:0];
    base   = {ofs[11:2], 2'b00};
    nbytes = (width == BYTE) ? 1 : ((width == HWORD) ? 2 : 4);
    if (int'(ofs[1:0]) + nbytes > 4) begin
        resp = RDY_ER;
    end else begin
        resp = RDY_OK;
        if (cmd == WR) begin
            for (i = 0; i < nbytes; i++) begin
                tcm_model[ofs + i] = wdata[8*i +: 8];
            end
        end
    end
    rdata = {tcm_model[base + 3], tcm_model[base + 2], tcm_model[base + 1], tcm_model[base]};
    xfer(name, cmd, width, addr, wdata, resp, rdata, (cmd == RD) && (resp == RDY_OK));
endtask

//----------------------------------------------------------
// Tests
//----------------------------------------------------------
task automatic check_reset_state();
    compare_val("reset resp", IDLE, dmem_resp);
    compare_val("reset req_ack", 1'b1, dmem_req_ack);
    compare_val("reset irq", 1'b0, timer_irq);
    end_test("reset_state");
endtask

task automatic run_tcm_traffic();
    scr1_addr_t addr;
    int         i;
    for (i = 0; i < SCR1_TCM_WORDS; i++) begin
        addr = SCR1_TCM_ADDR_PATTERN | scr1_addr_t'(i << 2);
        tcm_op("tcm fill", WR, WORD, addr, fill_word(addr));
    end
    repeat (400) begin
        addr = SCR1_TCM_ADDR_PATTERN | (scr1_addr_t'($random(seed)) & 32'h0000_0FFF);
        tcm_op("tcm random", rand_cmd(), rand_width(), addr, $random(seed));
        if (($random(seed) & 7) == 0) begin
            idle_cycle();           // Gap between requests now and then
        end
    end
    idle_cycle();
    end_test("tcm_random");
endtask

task automatic run_back_to_back();
    scr1_addr_t addr;
    repeat (64) begin
        if (($random(seed) & 1) != 0) begin
            addr = SCR1_TCM_ADDR_PATTERN | (scr1_addr_t'($random(seed)) & 32'h0000_0FFC);
            tcm_op("b2b tcm", rand_cmd(), WORD, addr, $random(seed));
        end else begin
            do begin
                addr = $random(seed);
            end while (in_tcm_window(addr) || in_timer_window(addr));
            xfer("b2b unmapped", rand_cmd(), rand_width(), addr, $random(seed),
                 RDY_ER, '0, 1'b1);
        end
    end
    idle_cycle();
    end_test("back_to_back");
endtask

task automatic check_timer_regs();
    scr1_data_t div_v;
    scr1_data_t lo_v;
    scr1_data_t hi_v;
    scr1_data_t cmp_lo_v;
    scr1_data_t cmp_hi_v;
    div_v    = $random(seed);
    lo_v     = $random(seed);
    hi_v     = $random(seed);
    cmp_lo_v = $random(seed);
    cmp_hi_v = $random(seed);
    xfer("div wr", WR, WORD, timer_addr(SCR1_TIMER_DIV), div_v, RDY_OK, '0, 1'b0);
    xfer("div rd", RD, WORD, timer_addr(SCR1_TIMER_DIV), '0, RDY_OK, div_v, 1'b1);
    xfer("mtimelo wr", WR, WORD, timer_addr(SCR1_TIMER_MTIMELO), lo_v, RDY_OK, '0, 1'b0);
    xfer("mtimehi wr", WR, WORD, timer_addr(SCR1_TIMER_MTIMEHI), hi_v, RDY_OK, '0, 1'b0);
    xfer("mtimelo rd", RD, WORD, timer_addr(SCR1_TIMER_MTIMELO), '0, RDY_OK, lo_v, 1'b1);
    xfer("mtimehi rd", RD, WORD, timer_addr(SCR1_TIMER_MTIMEHI), '0, RDY_OK, hi_v, 1'b1);
    compare_val("timer_val_o", {hi_v, lo_v}, timer_val);
    xfer("cmplo wr", WR, WORD, timer_addr(SCR1_TIMER_MTIMECMPLO), cmp_lo_v, RDY_OK, '0, 1'b0);
    xfer("cmphi wr", WR, WORD, timer_addr(SCR1_TIMER_MTIMECMPHI), cmp_hi_v, RDY_OK, '0, 1'b0);
    xfer("cmplo rd", RD, WORD, timer_addr(SCR1_TIMER_MTIMECMPLO), '0, RDY_OK, cmp_lo_v, 1'b1);
    xfer("cmphi rd", RD, WORD, timer_addr(SCR1_TIMER_MTIMECMPHI), '0, RDY_OK, cmp_hi_v, 1'b1);
    xfer("ctrl rd", RD, WORD, timer_addr(SCR1_TIMER_CTRL), '0, RDY_OK, '0, 1'b1);
    compare_val("irq while disabled", 1'b0, timer_irq);
    // Narrow and unknown accesses are refused and change nothing
    xfer("byte rd", RD, BYTE, timer_addr(SCR1_TIMER_MTIMELO), '0, RDY_ER, '0, 1'b0);
    xfer("hword wr", WR, HWORD, timer_addr(SCR1_TIMER_DIV), ~div_v, RDY_ER, '0, 1'b0);
    xfer("byte wr", WR, BYTE, timer_addr(SCR1_TIMER_DIV), ~div_v, RDY_ER, '0, 1'b0);
    xfer("bad ofs rd", RD, WORD, timer_addr(5'h18), '0, RDY_ER, '0, 1'b0);
    xfer("div rd again", RD, WORD, timer_addr(SCR1_TIMER_DIV), '0, RDY_OK, div_v, 1'b1);
    idle_cycle();
    end_test("timer_regs");
endtask

task automatic check_timer_irq();
    scr1_timer_val_t exp_mtime;
    scr1_timer_val_t target;
    int              wait_cnt;
    xfer("div wr", WR, WORD, timer_addr(SCR1_TIMER_DIV), '0, RDY_OK, '0, 1'b0);
    xfer("mtimelo wr", WR, WORD, timer_addr(SCR1_TIMER_MTIMELO), '0, RDY_OK, '0, 1'b0);
    xfer("mtimehi wr", WR, WORD, timer_addr(SCR1_TIMER_MTIMEHI), '0, RDY_OK, '0, 1'b0);
    xfer("cmplo wr", WR, WORD, timer_addr(SCR1_TIMER_MTIMECMPLO), '1, RDY_OK, '0, 1'b0);
    xfer("cmphi wr", WR, WORD, timer_addr(SCR1_TIMER_MTIMECMPHI), '1, RDY_OK, '0, 1'b0);
    xfer("ctrl enable", WR, WORD, timer_addr(SCR1_TIMER_CTRL), 32'h1, RDY_OK, '0, 1'b0);
    exp_mtime = 64'd0;              // Counting starts the cycle after the enable
    compare_val("mtime at enable", exp_mtime, timer_val);
    repeat (9) begin
        idle_cycle();
        exp_mtime = exp_mtime + 64'd1;     // DIV of zero, one per cycle
        compare_val("mtime step", exp_mtime, timer_val);
        compare_val("irq below cmp", 1'b0, timer_irq);
    end
    target = exp_mtime + 64'd40;
    xfer("cmplo wr", WR, WORD, timer_addr(SCR1_TIMER_MTIMECMPLO), target[31:0], RDY_OK, '0, 1'b0);
    xfer("cmphi wr", WR, WORD, timer_addr(SCR1_TIMER_MTIMECMPHI), target[63:32], RDY_OK, '0, 1'b0);
    wait_cnt = 0;
    while (!timer_irq) begin
        wait_cnt++;
        if (wait_cnt > 200) begin
            $display("timeout: timer_irq_o did not rise after mtimecmp was set");
            timeout_hit = 1'b1;
        end
        idle_cycle();
    end
    compare_val("mtime at irq", target, timer_val);
    xfer("ctrl disable", WR, WORD, timer_addr(SCR1_TIMER_CTRL), '0, RDY_OK, '0, 1'b0);
    compare_val("irq after disable", 1'b0, timer_irq);
    compare_val("mtime at disable", target + 64'd1, timer_val);    // Last step with the write
    idle_cycle();
    compare_val("mtime stopped", target + 64'd1, timer_val);
    end_test("timer_irq");
endtask

//----------------------------------------------------------
// Main sequence
//----------------------------------------------------------
initial begin
    clk              = 1'b0;
    core_rst_n_local = 1'b0;
    dmem_req         = 1'b0;
    dmem_cmd         = RD;
    dmem_width       = WORD;
    dmem_addr        = '0;
    dmem_wdata       = '0;
    seed             = 32'h44d6_6609;
    test_cnt         = 0;
    check_cnt        = 0;
    err_cnt          = 0;
    test_err_base    = 0;
    timeout_hit      = 1'b0;

    repeat (5) @(posedge clk);
    @(negedge clk);
    core_rst_n_local = 1'b1;

    check_reset_state();
    run_tcm_traffic();
    run_back_to_back();
    check_timer_regs();
    check_timer_irq();

    $display("tests: %0d, checks: %0d, errors: %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
        $display("SIMULATION PASSED");
    end else begin
        $display("SIMULATION FAILED");
    end
    $finish;
end

endmodule : tb_scr1_dmem

`default_nettype wire

// ==== vlog.f ====
verilog/scr1_dmem_pkg.sv
verilog/scr1_dmem_if.sv
verilog/scr1_dmem_router.sv
verilog/scr1_tcm.sv
verilog/scr1_timer.sv
verilog/scr1_dmem_top.sv
dv/tb_scr1_dmem.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the data memory testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

BUILD_DIR=build
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_scr1_dmem \
    --Mdir "${BUILD_DIR}" -o sim \
    -f vlog.f

"./${BUILD_DIR}/sim" 2>&1 | tee "${LOG_FILE}"

if grep -q "SIMULATION PASSED" "${LOG_FILE}"; then
    echo "run_sim: pass"
    exit 0
fi
echo "run_sim: fail, see ${LOG_FILE}"
exit 1
